// File: design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // ------------------------------------------------------------
    // widths with a meaning
    // ------------------------------------------------------------
    typedef logic signed [15:0] data_t;
    // register index, 7 marks an invalid field
    typedef logic [2:0] reg_idx_t;
    typedef logic [4:0] reg_code_t;
    typedef logic [4:0] shamt_t;
    typedef logic [2:0] op_t;

    // internal operation codes
    localparam op_t OP_ADDI  = 3'd0;
    localparam op_t OP_ADD   = 3'd1;
    localparam op_t OP_RELU  = 3'd2;
    localparam op_t OP_SHR   = 3'd3;
    localparam op_t OP_MULT  = 3'd4;
    localparam op_t OP_SHL   = 3'd5;
    localparam op_t OP_LEAKY = 3'd6;
    localparam op_t OP_FAIL  = 3'd7;

    // instruction opcodes
    localparam logic [5:0] OPC_RTYPE = 6'b000000;
    localparam logic [5:0] OPC_ADDI  = 6'b001000;

    // r-type funct field
    localparam logic [5:0] FN_ADD   = 6'b100000;
    localparam logic [5:0] FN_MULT  = 6'b011000;
    localparam logic [5:0] FN_SHL   = 6'b000000;
    localparam logic [5:0] FN_SHR   = 6'b000010;
    localparam logic [5:0] FN_RELU  = 6'b110001;
    localparam logic [5:0] FN_LEAKY = 6'b110010;

    // register address map, field code to register number
    localparam reg_code_t REG_CODE_0 = 5'b10001;
    localparam reg_code_t REG_CODE_1 = 5'b10010;
    localparam reg_code_t REG_CODE_2 = 5'b01000;
    localparam reg_code_t REG_CODE_3 = 5'b10111;
    localparam reg_code_t REG_CODE_4 = 5'b11111;
    localparam reg_code_t REG_CODE_5 = 5'b10000;

    localparam int       NUM_REGS = 6;
    localparam reg_idx_t IDX_NONE = 3'd7;

    // ------------------------------------------------------------
    // pipeline bundles
    // ------------------------------------------------------------
    // decoded instruction, one cycle after issue
    typedef struct packed {
        logic     valid;
        op_t      op;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t wr;
        data_t    imm;
        shamt_t   shamt;
        logic     fail;
    } dec_t;

    // writeback into the register file
    typedef struct packed {
        logic     valid;
        logic     fail;
        logic     wr_en;
        reg_idx_t wr;
        data_t    data;
    } wb_t;

endpackage

`default_nettype wire

// File: design/inst_decoder.sv
`default_nettype none

module inst_decoder (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          in_valid,
    input  wire logic [31:0]   instruction,
    output cpu_pkg::dec_t      dec
);

    // instruction fields
    logic [5:0]         opcode;
    logic [5:0]         funct;
    cpu_pkg::reg_idx_t  rs_map;
    cpu_pkg::reg_idx_t  rt_map;
    cpu_pkg::reg_idx_t  rd_map;
    cpu_pkg::op_t       op_nxt;
    logic               fail_nxt;

    // stage-1 registers
    logic               valid_q;
    cpu_pkg::op_t       op_q;
    cpu_pkg::reg_idx_t  rs_q;
    cpu_pkg::reg_idx_t  rt_q;
    cpu_pkg::reg_idx_t  wr_q;
    cpu_pkg::data_t     imm_q;
    cpu_pkg::shamt_t    shamt_q;
    logic               fail_q;

    // field code to register index, IDX_NONE if unmapped
    function automatic cpu_pkg::reg_idx_t map_reg(input cpu_pkg::reg_code_t code);
        cpu_pkg::reg_idx_t idx;
        case (code)
            cpu_pkg::REG_CODE_0: idx = 3'd0;
            cpu_pkg::REG_CODE_1: idx = 3'd1;
            cpu_pkg::REG_CODE_2: idx = 3'd2;
            cpu_pkg::REG_CODE_3: idx = 3'd3;
            cpu_pkg::REG_CODE_4: idx = 3'd4;
            cpu_pkg::REG_CODE_5: idx = 3'd5;
            default:             idx = cpu_pkg::IDX_NONE;
        endcase
        return idx;
    endfunction

    assign opcode = instruction[31:26];
    assign funct  = instruction[5:0];
    assign rs_map = map_reg(instruction[25:21]);
    assign rt_map = map_reg(instruction[20:16]);
    assign rd_map = map_reg(instruction[15:11]);

    // ------------------------------------------------------------
    // operation decode
    // ------------------------------------------------------------
    always_comb begin
        op_nxt = cpu_pkg::OP_FAIL;
        if (opcode == cpu_pkg::OPC_ADDI) begin
            op_nxt = cpu_pkg::OP_ADDI;
        end else if (opcode == cpu_pkg::OPC_RTYPE) begin
            case (funct)
                cpu_pkg::FN_ADD:   op_nxt = cpu_pkg::OP_ADD;
                cpu_pkg::FN_MULT:  op_nxt = cpu_pkg::OP_MULT;
                cpu_pkg::FN_SHL:   op_nxt = cpu_pkg::OP_SHL;
                cpu_pkg::FN_SHR:   op_nxt = cpu_pkg::OP_SHR;
                cpu_pkg::FN_RELU:  op_nxt = cpu_pkg::OP_RELU;
                cpu_pkg::FN_LEAKY: op_nxt = cpu_pkg::OP_LEAKY;
                default:           op_nxt = cpu_pkg::OP_FAIL;
            endcase
        end
    end

    // addi only needs rs and rt, r-type also needs rd
    assign fail_nxt = (op_nxt == cpu_pkg::OP_FAIL)
                   || (rs_map == cpu_pkg::IDX_NONE)
                   || (rt_map == cpu_pkg::IDX_NONE)
                   || ((op_nxt != cpu_pkg::OP_ADDI) && (rd_map == cpu_pkg::IDX_NONE));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        op_q    <= op_nxt;
        rs_q    <= rs_map;
        rt_q    <= rt_map;
        // destination is rt for addi
        wr_q    <= (op_nxt == cpu_pkg::OP_ADDI) ? rt_map : rd_map;
        imm_q   <= instruction[15:0];
        shamt_q <= instruction[10:6];
        fail_q  <= fail_nxt;
    end

    assign dec = '{valid: valid_q, op: op_q, rs: rs_q, rt: rt_q, wr: wr_q,
                   imm: imm_q, shamt: shamt_q, fail: fail_q};

endmodule

`default_nettype wire

// File: design/radix4_multiplier.sv
`default_nettype none

module radix4_multiplier #(
    parameter int FRAC_BITS = 15
) (
    input  wire logic        clk,
    input  wire cpu_pkg::data_t a,
    input  wire cpu_pkg::data_t b,
    output cpu_pkg::data_t   product
);

    // sign and magnitude of the operands
    logic        sign;
    logic [15:0] a_mag;
    logic [15:0] b_mag;
    logic [1:0]  a_dig [8];
    logic [1:0]  b_dig [8];

    // stage A registers
    logic        sign_q1;
    logic [3:0]  pp_q [8][8];

    // stage B
    logic [6:0]  col [15];
    logic [9:0]  pair [8];
    logic [9:0]  pair_q [8];
    logic        sign_q2;

    // stage C
    logic [31:0]        mag;
    logic signed [31:0] prod_s;
    logic signed [31:0] prod_sh;

    assign sign  = a[15] ^ b[15];
    // -32768 maps to 0x8000, still fits 16 bits unsigned
    assign a_mag = a[15] ? 16'(-a) : 16'(a);
    assign b_mag = b[15] ? 16'(-b) : 16'(b);

    // ------------------------------------------------------------
    // stage A, 2-bit digit products
    // ------------------------------------------------------------
    for (genvar d = 0; d < 8; d++) begin : g_digit
        assign a_dig[d] = a_mag[2*d +: 2];
        assign b_dig[d] = b_mag[2*d +: 2];
    end

    for (genvar i = 0; i < 8; i++) begin : g_pp_row
        for (genvar j = 0; j < 8; j++) begin : g_pp_col
            always_ff @(posedge clk) begin
                pp_q[i][j] <= 4'(a_dig[i]) * 4'(b_dig[j]);
            end
        end
    end

    always_ff @(posedge clk) begin
        sign_q1 <= sign;
        sign_q2 <= sign_q1;
    end

    // ------------------------------------------------------------
    // stage B, column sums then pairs of columns
    // ------------------------------------------------------------
    // column k holds every digit product of weight 4^k
    always_comb begin
        for (int k = 0; k < 15; k++) begin
            col[k] = '0;
        end
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8; j++) begin
                col[i+j] = col[i+j] + 7'(pp_q[i][j]);
            end
        end
    end

    // pair m carries weight 16^m
    for (genvar m = 0; m < 8; m++) begin : g_pair
        if (m < 7) begin : g_two
            assign pair[m] = 10'(col[2*m]) + (10'(col[2*m+1]) << 2);
        end else begin : g_top
            assign pair[m] = 10'(col[2*m]);
        end
        always_ff @(posedge clk) begin
            pair_q[m] <= pair[m];
        end
    end

    // ------------------------------------------------------------
    // stage C, final sum, sign, fixed-point scale
    // ------------------------------------------------------------
    always_comb begin
        mag = '0;
        for (int m = 0; m < 8; m++) begin
            mag = mag + (32'(pair_q[m]) << (4*m));
        end
    end

    // magnitude peaks at 2^30 so the signed form never overflows
    assign prod_s  = sign_q2 ? -$signed(mag) : $signed(mag);
    // arithmetic shift rounds toward minus infinity
    assign prod_sh = prod_s >>> FRAC_BITS;
    assign product = prod_sh[15:0];

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`default_nettype none

module execute_stage (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire cpu_pkg::dec_t   dec,
    input  wire cpu_pkg::data_t  rs_data,
    input  wire cpu_pkg::data_t  rt_data,
    input  wire cpu_pkg::data_t  product,
    output cpu_pkg::reg_idx_t    rs_idx,
    output cpu_pkg::reg_idx_t    rt_idx,
    output cpu_pkg::wb_t         wb
);

    // control that rides along with the data
    typedef struct packed {
        logic              valid;
        logic              fail;
        logic              use_mul;
        cpu_pkg::reg_idx_t wr;
    } ctl_t;

    logic            nonneg;
    logic            use_mul;
    cpu_pkg::data_t  addend;
    cpu_pkg::data_t  sum;
    cpu_pkg::data_t  data_1;
    ctl_t            ctl_1;

    // two-deep delay to line up with the multiplier
    ctl_t            ctl_q [2];
    cpu_pkg::data_t  data_q [2];

    // operands are read straight from the register file
    assign rs_idx = dec.rs;
    assign rt_idx = dec.rt;

    // ------------------------------------------------------------
    // stage 1 datapath
    // ------------------------------------------------------------
    assign nonneg = ~rt_data[15];

    // second adder input, rt for add, immediate for addi
    assign addend = (dec.op == cpu_pkg::OP_ADD) ? rt_data : dec.imm;
    assign sum    = rs_data + addend;

    always_comb begin
        case (dec.op)
            cpu_pkg::OP_ADD,
            cpu_pkg::OP_ADDI:  data_1 = sum;
            cpu_pkg::OP_SHL:   data_1 = rt_data <<< dec.shamt;
            cpu_pkg::OP_SHR:   data_1 = rt_data >>> dec.shamt;
            // negative leaky input is replaced by the product later
            cpu_pkg::OP_RELU,
            cpu_pkg::OP_LEAKY: data_1 = nonneg ? rt_data : '0;
            default:           data_1 = '0;
        endcase
    end

    assign use_mul = (dec.op == cpu_pkg::OP_MULT)
                  || ((dec.op == cpu_pkg::OP_LEAKY) && !nonneg);

    assign ctl_1 = '{valid: dec.valid, fail: dec.fail, use_mul: use_mul, wr: dec.wr};

    // ------------------------------------------------------------
    // stages 2 and 3
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctl_q[0] <= '0;
            ctl_q[1] <= '0;
        end else begin
            ctl_q[0] <= ctl_1;
            ctl_q[1] <= ctl_q[0];
        end
    end

    always_ff @(posedge clk) begin
        data_q[0] <= data_1;
        data_q[1] <= data_q[0];
    end

    // merge with the multiplier output, failed instructions never write
    assign wb = '{valid: ctl_q[1].valid,
                  fail:  ctl_q[1].fail,
                  wr_en: ctl_q[1].valid & ~ctl_q[1].fail,
                  wr:    ctl_q[1].wr,
                  data:  ctl_q[1].use_mul ? product : data_q[1]};

endmodule

`default_nettype wire

// File: design/reg_file.sv
`default_nettype none

module reg_file (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire cpu_pkg::reg_idx_t  rs_idx,
    input  wire cpu_pkg::reg_idx_t  rt_idx,
    input  wire cpu_pkg::wb_t       wb,
    output cpu_pkg::data_t          rs_data,
    output cpu_pkg::data_t          rt_data,
    output logic                    out_valid,
    output logic                    instruction_fail,
    output cpu_pkg::data_t          out_0,
    output cpu_pkg::data_t          out_1,
    output cpu_pkg::data_t          out_2,
    output cpu_pkg::data_t          out_3,
    output cpu_pkg::data_t          out_4,
    output cpu_pkg::data_t          out_5
);

    cpu_pkg::data_t regs [cpu_pkg::NUM_REGS];

    // ------------------------------------------------------------
    // register array and writeback
    // ------------------------------------------------------------
    for (genvar g = 0; g < cpu_pkg::NUM_REGS; g++) begin : g_reg
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                regs[g] <= '0;
            end else if (wb.wr_en && (wb.wr == 3'(g))) begin
                regs[g] <= wb.data;
            end
        end
    end

    // read ports, no bypass of the write in flight
    assign rs_data = (rs_idx < 3'(cpu_pkg::NUM_REGS)) ? regs[rs_idx] : '0;
    assign rt_data = (rt_idx < 3'(cpu_pkg::NUM_REGS)) ? regs[rt_idx] : '0;

    // strobe and fail flag land on the same edge as the write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid        <= 1'b0;
            instruction_fail <= 1'b0;
        end else begin
            out_valid        <= wb.valid;
            instruction_fail <= wb.valid & wb.fail;
        end
    end

    // outputs read zero between strobes
    assign out_0 = out_valid ? regs[0] : '0;
    assign out_1 = out_valid ? regs[1] : '0;
    assign out_2 = out_valid ? regs[2] : '0;
    assign out_3 = out_valid ? regs[3] : '0;
    assign out_4 = out_valid ? regs[4] : '0;
    assign out_5 = out_valid ? regs[5] : '0;

endmodule

`default_nettype wire

// File: design/cpu_top.sv
`default_nettype none

module cpu_top #(
    parameter int FRAC_BITS = 15
) (
    input  wire logic         clk,
    input  wire logic         rst_n,
    input  wire logic         in_valid,
    input  wire logic [31:0]  instruction,
    output logic              out_valid,
    output logic              instruction_fail,
    output cpu_pkg::data_t    out_0,
    output cpu_pkg::data_t    out_1,
    output cpu_pkg::data_t    out_2,
    output cpu_pkg::data_t    out_3,
    output cpu_pkg::data_t    out_4,
    output cpu_pkg::data_t    out_5
);

    // ------------------------------------------------------------
    // inter-stage wires
    // ------------------------------------------------------------
    cpu_pkg::dec_t      dec;
    cpu_pkg::reg_idx_t  rs_idx;
    cpu_pkg::reg_idx_t  rt_idx;
    cpu_pkg::data_t     rs_data;
    cpu_pkg::data_t     rt_data;
    cpu_pkg::data_t     product;
    cpu_pkg::wb_t       wb;

    // issue to stage 1
    inst_decoder i_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .instruction (instruction),
        .dec         (dec)
    );

    // stage 1 through 3 for everything except the product
    execute_stage i_execute (
        .clk     (clk),
        .rst_n   (rst_n),
        .dec     (dec),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .product (product),
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .wb      (wb)
    );

    // same operands as the execute stage, two cycles deep
    radix4_multiplier #(
        .FRAC_BITS (FRAC_BITS)
    ) i_mult (
        .clk     (clk),
        .a       (rs_data),
        .b       (rt_data),
        .product (product)
    );

    reg_file i_regs (
        .clk              (clk),
        .rst_n            (rst_n),
        .rs_idx           (rs_idx),
        .rt_idx           (rt_idx),
        .wb               (wb),
        .rs_data          (rs_data),
        .rt_data          (rt_data),
        .out_valid        (out_valid),
        .instruction_fail (instruction_fail),
        .out_0            (out_0),
        .out_1            (out_1),
        .out_2            (out_2),
        .out_3            (out_3),
        .out_4            (out_4),
        .out_5            (out_5)
    );

endmodule

`default_nettype wire

// File: tb/cpu_tests.svh
`ifndef CPU_TESTS_SVH
`define CPU_TESTS_SVH

// ------------------------------------------------------------
// instruction builders
// ------------------------------------------------------------
function automatic logic [31:0] enc_r(input int rs, input int rt, input int rd,
                                      input int shamt, input logic [5:0] funct);
    return {cpu_pkg::OPC_RTYPE, code_of(rs), code_of(rt), code_of(rd), 5'(shamt), funct};
endfunction

function automatic logic [31:0] enc_i(input int rs, input int rt, input cpu_pkg::data_t imm);
    return {cpu_pkg::OPC_ADDI, code_of(rs), code_of(rt), imm};
endfunction

// mostly valid registers, index 7 now and then
function automatic int pick_reg();
    int r;
    r = int'($urandom_range(0, 12));
    return (r == 12) ? 7 : r % 6;
endfunction

// result visible to the next instruction
task automatic issue_spaced(input logic [31:0] instr);
    step(1'b1, instr);
    repeat (3) begin
        step(1'b0, '0);
    end
endtask

// shift by 16 clears the register, then addi sets it
task automatic load_reg(input int idx, input cpu_pkg::data_t value);
    issue_spaced(enc_r(idx, idx, idx, 16, cpu_pkg::FN_SHL));
    issue_spaced(enc_i(idx, idx, value));
endtask

// ------------------------------------------------------------
// directed tests
// ------------------------------------------------------------
// outputs stay zero while idle
task automatic test_reset();
    repeat (4) begin
        step(1'b0, '0);
    end
endtask

task automatic test_arith();
    issue_spaced(enc_i(0, 0, 16'sd100));
    issue_spaced(enc_i(1, 1, -16'sd250));
    issue_spaced(enc_i(0, 2, 16'sd7));
    issue_spaced(enc_r(0, 1, 3, 0, cpu_pkg::FN_ADD));
    issue_spaced(enc_r(3, 2, 4, 0, cpu_pkg::FN_ADD));
    // wraps past the top of the range
    issue_spaced(enc_i(4, 5, 16'sd32767));
    issue_spaced(enc_r(5, 5, 5, 0, cpu_pkg::FN_ADD));
    issue_spaced(enc_r(1, 1, 0, 0, cpu_pkg::FN_ADD));
    issue_spaced(enc_i(1, 1, 16'sd250));
    issue_spaced(enc_i(4, 4, -16'sd1));
endtask

task automatic test_shift_relu();
    // positive, negative and zero sources
    load_reg(0, 16'sh1234);
    load_reg(1, 16'shB3C5);
    load_reg(2, 16'sd0);
    for (int sh = 0; sh < 16; sh++) begin
        for (int src = 0; src < 3; src++) begin
            issue_spaced(enc_r(src, src, 3, sh, cpu_pkg::FN_SHL));
            issue_spaced(enc_r(src, src, 4, sh, cpu_pkg::FN_SHR));
        end
    end
    for (int src = 0; src < 3; src++) begin
        issue_spaced(enc_r(1, src, 5, 0, cpu_pkg::FN_RELU));
        issue_spaced(enc_r(0, src, 5, 0, cpu_pkg::FN_LEAKY));
    end
endtask

task automatic test_mult();
    cpu_pkg::data_t a;
    cpu_pkg::data_t b;
    for (int n = 0; n < MULT_PAIRS; n++) begin
        a = cpu_pkg::data_t'($urandom);
        b = cpu_pkg::data_t'($urandom);
        // most negative value on either side
        if (n == 0) begin
            a = 16'sh8000;
            b = 16'sh8000;
        end
        if (n == 1) begin
            a = 16'sh8000;
        end
        if (n == 2) begin
            b = 16'sh8000;
        end
        load_reg(0, a);
        load_reg(1, b);
        issue_spaced(enc_r(0, 1, 2, 0, cpu_pkg::FN_MULT));
        issue_spaced(enc_r(0, 1, 3, 0, cpu_pkg::FN_LEAKY));
    end
endtask

task automatic test_fail();
    issue_spaced({6'b111111, code_of(0), code_of(1), code_of(2), 5'd0, cpu_pkg::FN_ADD});
    issue_spaced(enc_r(0, 1, 2, 0, 6'b101010));
    issue_spaced(enc_r(7, 1, 2, 0, cpu_pkg::FN_ADD));
    issue_spaced(enc_r(0, 7, 2, 0, cpu_pkg::FN_MULT));
    issue_spaced(enc_r(0, 1, 7, 0, cpu_pkg::FN_ADD));
    issue_spaced(enc_i(0, 7, 16'sd5));
    issue_spaced(enc_i(7, 0, 16'sd5));
    // unmapped rd bits inside an addi immediate are fine
    issue_spaced(enc_i(0, 3, 16'sd5));
endtask

// back to back, no idle slots
task automatic test_stream();
    logic [31:0] instr;
    logic [5:0]  fn;
    int          kind;
    for (int n = 0; n < STREAM_N; n++) begin
        kind = int'($urandom_range(0, 9));
        case (kind)
            1:       fn = cpu_pkg::FN_ADD;
            2:       fn = cpu_pkg::FN_MULT;
            3:       fn = cpu_pkg::FN_SHL;
            4:       fn = cpu_pkg::FN_SHR;
            5:       fn = cpu_pkg::FN_RELU;
            6:       fn = cpu_pkg::FN_LEAKY;
            default: fn = 6'b111110;
        endcase
        if (kind == 0 || kind == 9) begin
            instr = enc_i(pick_reg(), pick_reg(), cpu_pkg::data_t'($urandom));
        end else if (kind == 8) begin
            instr = {6'b000100, code_of(pick_reg()), code_of(pick_reg()), 16'h1234};
        end else begin
            instr = enc_r(pick_reg(), pick_reg(), pick_reg(), int'($urandom_range(0, 15)), fn);
        end
        step(1'b1, instr);
    end
endtask

`endif

// File: tb/tb_cpu.sv
`default_nettype none

module tb_cpu;

    localparam int FRAC_BITS  = 15;
    localparam int CLK_PERIOD = 40;

    // instructions issued by each test
    localparam int ARITH_N    = 10;
    localparam int SHIFT_N    = 6 + 16 * 3 * 2 + 6;
    localparam int MULT_PAIRS = 40;
    localparam int FAIL_N     = 8;
    localparam int STREAM_N   = 60;
    localparam int RUN_SLOTS  = 5 + 4 + 4 * (ARITH_N + SHIFT_N + 6 * MULT_PAIRS + FAIL_N)
                              + STREAM_N + 8;
    localparam int TIMEOUT    = (RUN_SLOTS + 50) * CLK_PERIOD;

    // one instruction in flight in the reference model
    typedef struct packed {
        logic              valid;
        logic              fail;
        cpu_pkg::reg_idx_t wr;
        cpu_pkg::data_t    data;
    } slot_t;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            in_valid;
    logic [31:0]     instruction;
    logic            out_valid;
    logic            instruction_fail;
    cpu_pkg::data_t  out_0;
    cpu_pkg::data_t  out_1;
    cpu_pkg::data_t  out_2;
    cpu_pkg::data_t  out_3;
    cpu_pkg::data_t  out_4;
    cpu_pkg::data_t  out_5;
    cpu_pkg::data_t  dut_regs [6];

    // reference model state
    slot_t           pipe [3];
    cpu_pkg::data_t  shadow [6];
    logic            snap_valid;
    logic            snap_fail;
    cpu_pkg::data_t  snap_regs [6];
    logic            exp_valid;
    logic            exp_fail;
    cpu_pkg::data_t  exp_regs [6];
    int              errors;
    int              checks;

    cpu_top #(
        .FRAC_BITS (FRAC_BITS)
    ) i_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .instruction      (instruction),
        .out_valid        (out_valid),
        .instruction_fail (instruction_fail),
        .out_0            (out_0),
        .out_1            (out_1),
        .out_2            (out_2),
        .out_3            (out_3),
        .out_4            (out_4),
        .out_5            (out_5)
    );

    assign dut_regs[0] = out_0;
    assign dut_regs[1] = out_1;
    assign dut_regs[2] = out_2;
    assign dut_regs[3] = out_3;
    assign dut_regs[4] = out_4;
    assign dut_regs[5] = out_5;

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    // register index to its field code
    // other indices get an unmapped code
    function automatic cpu_pkg::reg_code_t code_of(input int idx);
        case (idx)
            0:       return cpu_pkg::REG_CODE_0;
            1:       return cpu_pkg::REG_CODE_1;
            2:       return cpu_pkg::REG_CODE_2;
            3:       return cpu_pkg::REG_CODE_3;
            4:       return cpu_pkg::REG_CODE_4;
            5:       return cpu_pkg::REG_CODE_5;
            default: return 5'b00000;
        endcase
    endfunction

    // -1 for a code outside the map
    function automatic int idx_of(input cpu_pkg::reg_code_t code);
        for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
            if (code_of(i) == code) begin
                return i;
            end
        end
        return -1;
    endfunction

    // floor of a*b over 2^FRAC_BITS
    // only the low 16 bits are kept
    function automatic cpu_pkg::data_t fx_mul(input cpu_pkg::data_t a, input cpu_pkg::data_t b);
        longint p;
        p = longint'(a) * longint'(b);
        p = p >>> FRAC_BITS;
        return p[15:0];
    endfunction

    function automatic slot_t predict(input logic valid, input logic [31:0] instr);
        slot_t          s;
        int             rs;
        int             rt;
        int             rd;
        logic [5:0]     funct;
        logic [4:0]     shamt;
        logic           known;
        cpu_pkg::data_t a;
        cpu_pkg::data_t b;
        funct = instr[5:0];
        shamt = instr[10:6];
        rs    = idx_of(instr[25:21]);
        rt    = idx_of(instr[20:16]);
        rd    = idx_of(instr[15:11]);
        a     = (rs >= 0) ? shadow[rs] : '0;
        b     = (rt >= 0) ? shadow[rt] : '0;
        s       = '0;
        s.valid = valid;
        if (instr[31:26] == cpu_pkg::OPC_ADDI) begin
            // addi writes rt and its rd bits belong to the immediate
            s.fail = (rs < 0) || (rt < 0);
            s.wr   = 3'(rt);
            s.data = a + cpu_pkg::data_t'(instr[15:0]);
        end else if (instr[31:26] == cpu_pkg::OPC_RTYPE) begin
            known = 1'b1;
            s.wr  = 3'(rd);
            case (funct)
                cpu_pkg::FN_ADD:   s.data = a + b;
                cpu_pkg::FN_MULT:  s.data = fx_mul(a, b);
                cpu_pkg::FN_SHL:   s.data = b << shamt;
                cpu_pkg::FN_SHR:   s.data = b >>> shamt;
                cpu_pkg::FN_RELU:  s.data = (b < 0) ? '0 : b;
                cpu_pkg::FN_LEAKY: s.data = (b < 0) ? fx_mul(a, b) : b;
                default:           known = 1'b0;
            endcase
            s.fail = !known || (rs < 0) || (rt < 0) || (rd < 0);
        end else begin
            s.fail = 1'b1;
        end
        return s;
    endfunction

    task automatic clear_model();
        for (int i = 0; i < 3; i++) begin
            pipe[i] = '0;
        end
        for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
            shadow[i]    = '0;
            snap_regs[i] = '0;
            exp_regs[i]  = '0;
        end
        snap_valid = 1'b0;
        snap_fail  = 1'b0;
        exp_valid  = 1'b0;
        exp_fail   = 1'b0;
    endtask

    // one clock of stimulus with the model stepped in the same slot
    task automatic step(input logic valid, input logic [31:0] instr);
        slot_t cur;
        @(posedge clk);
        // result of the instruction four slots back shows after this edge
        exp_valid = snap_valid;
        exp_fail  = snap_fail;
        exp_regs  = snap_regs;
        // writeback of the instruction three slots back
        if (pipe[2].valid && !pipe[2].fail) begin
            shadow[pipe[2].wr] = pipe[2].data;
        end
        snap_valid = pipe[2].valid;
        snap_fail  = pipe[2].valid & pipe[2].fail;
        for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
            snap_regs[i] = pipe[2].valid ? shadow[i] : '0;
        end
        cur     = predict(valid, instr);
        pipe[2] = pipe[1];
        pipe[1] = pipe[0];
        pipe[0] = cur;
        in_valid    <= valid;
        instruction <= instr;
    endtask

    task automatic reset_dut();
        rst_n <= 1'b0;
        repeat (5) begin
            step(1'b0, '0);
        end
        rst_n <= 1'b1;
    endtask

    // ------------------------------------------------------------
    // output checks at the falling edge
    // ------------------------------------------------------------
    task automatic report_error(input string what, input int got, input int want);
        errors++;
        $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, want);
    endtask

    always @(negedge clk) begin
        checks++;
        assert (out_valid === exp_valid)
            else report_error("out_valid", int'(out_valid), int'(exp_valid));
        assert (instruction_fail === exp_fail)
            else report_error("instruction_fail", int'(instruction_fail), int'(exp_fail));
        for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
            assert (dut_regs[i] === exp_regs[i])
                else report_error($sformatf("out_%0d", i), int'(dut_regs[i]),
                                  int'(exp_regs[i]));
        end
    end

    `include "cpu_tests.svh"

    initial begin
        void'($urandom(23470));
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        instruction = '0;
        errors      = 0;
        checks      = 0;
        clear_model();
        reset_dut();
        test_reset();
        test_arith();
        test_shift_relu();
        test_mult();
        test_fail();
        test_stream();
        // drain the pipeline
        repeat (6) begin
            step(1'b0, '0);
        end
        @(posedge clk);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT);
        $display("timeout: the tests did not finish within %0d time units", TIMEOUT);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: cpu_pipe.f
+incdir+tb
design/cpu_pkg.sv
design/inst_decoder.sv
design/radix4_multiplier.sv
design/execute_stage.sv
design/reg_file.sv
design/cpu_top.sv
tb/tb_cpu.sv

// File: Makefile
# Verilator flow for the cpu_pipe testbench

RTL := design/cpu_pkg.sv design/inst_decoder.sv design/radix4_multiplier.sv \
       design/execute_stage.sv design/reg_file.sv design/cpu_top.sv

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module tb_cpu -f cpu_pipe.f -o Vtb_cpu

# the log decides pass or fail
run: build
	./obj_dir/Vtb_cpu | tee sim.log
	grep -qx "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only -Wall --top-module cpu_top $(RTL)

clean:
	rm -rf obj_dir sim.log
